// ==== dep_check_top.f ====
+incdir+include
src/dep_check_pkg.sv
src/uop_gather.sv
src/raw_dep_matrix.sv
src/dep_encoder.sv
src/dep_check_top.sv
sim/tb_dep_check.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile with Verilator, run, and search the log for the fail message
set -e

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir "$LOG"

verilator --binary --timing --assert \
    -f dep_check_top.f \
    --top-module tb_dep_check \
    -o tb_dep_check

./obj_dir/tb_dep_check > "$LOG" 2>&1
cat "$LOG"

if grep -q "Testbench failed" "$LOG"; then
    echo "Simulation reported failure"
    exit 1
fi

echo "Simulation finished without failure"

// ==== sim/tb_dep_check.sv ====
`include "dep_check_config.svh"

module tb_dep_check
    import dep_check_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT = 200;

    logic       w_fire2_2;
    logic       rstn;
    logic       i_drive;
    logic       o_free;
    uop_t       i_uops [`DC_LANES];
    logic       o_drive;
    dep_entry_t o_entries [`DC_WINDOW];
    logic       i_free;

    uop_t       win [`DC_WINDOW];
    dep_entry_t exp_q [$];
    int         errors;
    int         checks;
    int         cyc;
    int         accept_cyc;
    int         drive_cyc;

    dep_check_top DUT (
        .w_fire2_2 (w_fire2_2),
        .rstn      (rstn),
        .i_drive   (i_drive),
        .o_free    (o_free),
        .i_uops    (i_uops),
        .o_drive   (o_drive),
        .o_entries (o_entries),
        .i_free    (i_free)
    );

    initial begin
        w_fire2_2 = 1'b0;
        forever #4 w_fire2_2 = ~w_fire2_2;
    end

    always @(posedge w_fire2_2) begin
        cyc <= cyc + 1;
    end

    task automatic finish_run();
        $display("Closing: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    endtask

    task automatic check_val(input string name, input dep_entry_t got, input dep_entry_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR t=%0t %s got=%h exp=%h", $time, name, got, exp);
        end
    endtask

    task automatic next_cycle();
        @(posedge w_fire2_2);
        #1;
    endtask

    function automatic uop_t make_uop(input bit dv, input bit rv, input bit lv,
                                      input reg_num_t d, input reg_num_t r, input reg_num_t l);
        uop_t u;
        u = uop_t'({$urandom, $urandom, $urandom, $urandom});
        u[`DC_DEST_LSB +: `DC_REG_W] = d;
        u[`DC_SRCR_LSB +: `DC_REG_W] = r;
        u[`DC_SRCL_LSB +: `DC_REG_W] = l;
        u[`DC_DEST_VLD] = dv;
        u[`DC_SRCR_VLD] = rv;
        u[`DC_SRCL_VLD] = lv;
        return u;
    endfunction

    // Walk back from the slot and keep the first matching writer
    function automatic dep_entry_t model_entry(input int j);
        slot_idx_t l_idx;
        slot_idx_t r_idx;
        bit        l_found;
        bit        r_found;
        reg_num_t  dest;
        l_idx = `DC_NO_DEP;
        r_idx = `DC_NO_DEP;
        l_found = 1'b0;
        r_found = 1'b0;
        for (int k = j - 1; k >= 0; k--) begin
            dest = win[k][`DC_DEST_LSB +: `DC_REG_W];
            if (win[k][`DC_DEST_VLD]) begin
                if (!l_found && win[j][`DC_SRCL_VLD] &&
                    dest == win[j][`DC_SRCL_LSB +: `DC_REG_W]) begin
                    l_idx = slot_idx_t'(k);
                    l_found = 1'b1;
                end
                if (!r_found && win[j][`DC_SRCR_VLD] &&
                    dest == win[j][`DC_SRCR_LSB +: `DC_REG_W]) begin
                    r_idx = slot_idx_t'(k);
                    r_found = 1'b1;
                end
            end
        end
        return {win[j], l_idx, r_idx};
    endfunction

    task automatic clear_window();
        for (int j = 0; j < `DC_WINDOW; j++) begin
            win[j] = make_uop(0, 0, 0, reg_num_t'($urandom), reg_num_t'($urandom),
                              reg_num_t'($urandom));
        end
    endtask

    task automatic wait_free();
        int n;
        n = 0;
        while (!o_free) begin
            next_cycle();
            n++;
            if (n > TIMEOUT) begin
                $display("Timeout: o_free stayed low for %0d cycles", TIMEOUT);
                errors++;
                finish_run();
            end
        end
    endtask

    task automatic wait_drive();
        int n;
        n = 0;
        while (!o_drive) begin
            next_cycle();
            n++;
            if (n > TIMEOUT) begin
                $display("Timeout: no output window after %0d cycles", TIMEOUT);
                errors++;
                finish_run();
            end
        end
        drive_cyc = cyc;
    endtask

    // Two beats, low half first
    task automatic send_window();
        for (int b = 0; b < 2; b++) begin
            wait_free();
            i_drive = 1'b1;
            for (int i = 0; i < `DC_LANES; i++) begin
                i_uops[i] = win[b * `DC_LANES + i];
            end
            next_cycle();
            i_drive = 1'b0;
        end
        accept_cyc = cyc;
        for (int j = 0; j < `DC_WINDOW; j++) begin
            exp_q.push_back(model_entry(j));
        end
    endtask

    task automatic receive_window();
        wait_drive();
        if (exp_q.size() < `DC_WINDOW) begin
            $display("An output window appeared that was never sent");
            errors++;
        end else begin
            for (int j = 0; j < `DC_WINDOW; j++) begin
                check_val($sformatf("o_entries[%0d]", j), o_entries[j], exp_q.pop_front());
            end
        end
    endtask

    task automatic release_window();
        i_free = 1'b1;
        next_cycle();
        i_free = 1'b0;
    endtask

    task automatic test_reset_latency();
        check_val("o_drive", dep_entry_t'(o_drive), '0);
        check_val("o_free", dep_entry_t'(o_free), dep_entry_t'(1));
        for (int j = 0; j < `DC_WINDOW; j++) begin
            check_val($sformatf("reset o_entries[%0d]", j), o_entries[j], '0);
        end
        clear_window();
        send_window();
        receive_window();
        check_val("o_drive latency", dep_entry_t'(drive_cyc - accept_cyc), dep_entry_t'(2));
        release_window();
    endtask

    task automatic test_no_flags();
        clear_window();
        send_window();
        receive_window();
        for (int j = 0; j < `DC_WINDOW; j++) begin
            check_val($sformatf("o_entries[%0d] indices", j),
                      dep_entry_t'(o_entries[j][7:0]), dep_entry_t'(8'hFF));
        end
        release_window();
    endtask

    task automatic test_chains();
        clear_window();
        win[2]  = make_uop(1, 0, 0, 5'd5, 5'd0, 5'd0);
        win[4]  = make_uop(1, 0, 0, 5'd5, 5'd0, 5'd0);
        win[6]  = make_uop(0, 0, 1, 5'd0, 5'd0, 5'd5);
        win[3]  = make_uop(1, 0, 0, 5'd9, 5'd0, 5'd0);
        win[12] = make_uop(0, 1, 0, 5'd0, 5'd9, 5'd0);
        win[7]  = make_uop(0, 0, 1, 5'd0, 5'd0, 5'd20);
        win[10] = make_uop(1, 0, 0, 5'd20, 5'd0, 5'd0);
        send_window();
        receive_window();
        check_val("o_entries[6] left", dep_entry_t'(o_entries[6][7:4]), dep_entry_t'(4));
        check_val("o_entries[12] right", dep_entry_t'(o_entries[12][3:0]), dep_entry_t'(3));
        check_val("o_entries[7] left", dep_entry_t'(o_entries[7][7:4]), dep_entry_t'(15));
        release_window();
    endtask

    task automatic test_valid_gating();
        clear_window();
        win[1] = make_uop(0, 0, 0, 5'd7, 5'd0, 5'd0);
        win[5] = make_uop(0, 0, 1, 5'd0, 5'd0, 5'd7);
        win[2] = make_uop(1, 0, 0, 5'd8, 5'd0, 5'd0);
        win[6] = make_uop(0, 0, 0, 5'd0, 5'd8, 5'd0);
        send_window();
        receive_window();
        check_val("o_entries[5] left", dep_entry_t'(o_entries[5][7:4]), dep_entry_t'(15));
        check_val("o_entries[6] right", dep_entry_t'(o_entries[6][3:0]), dep_entry_t'(15));
        release_window();
    endtask

    // Few register numbers so that chains show up often
    task automatic random_fill();
        for (int j = 0; j < `DC_WINDOW; j++) begin
            win[j] = make_uop($urandom_range(1, 0) == 1, $urandom_range(1, 0) == 1,
                              $urandom_range(1, 0) == 1, reg_num_t'($urandom_range(7, 0)),
                              reg_num_t'($urandom_range(7, 0)),
                              reg_num_t'($urandom_range(7, 0)));
        end
    endtask

    task automatic test_random();
        for (int w = 0; w < 20; w++) begin
            random_fill();
            send_window();
            receive_window();
            release_window();
        end
    endtask

    task automatic test_back_pressure();
        dep_entry_t held [`DC_WINDOW];
        for (int w = 0; w < 3; w++) begin
            random_fill();
            send_window();
        end
        check_val("o_free", dep_entry_t'(o_free), '0);
        wait_drive();
        held = o_entries;
        repeat (5) next_cycle();
        check_val("o_drive", dep_entry_t'(o_drive), dep_entry_t'(1));
        for (int j = 0; j < `DC_WINDOW; j++) begin
            check_val($sformatf("held o_entries[%0d]", j), o_entries[j], held[j]);
        end
        for (int w = 0; w < 3; w++) begin
            receive_window();
            release_window();
        end
        check_val("o_drive", dep_entry_t'(o_drive), '0);
        check_val("o_free", dep_entry_t'(o_free), dep_entry_t'(1));
        if (exp_q.size() != 0) begin
            $display("Windows were sent but never came out");
            errors++;
        end
    endtask

    initial begin
        void'($urandom(32'h2ade1fb9));
        errors = 0;
        checks = 0;
        cyc = 0;
        rstn = 1'b0;
        i_drive = 1'b0;
        i_free = 1'b0;
        for (int i = 0; i < `DC_LANES; i++) begin
            i_uops[i] = '0;
        end
        repeat (4) @(posedge w_fire2_2);
        #1;
        rstn = 1'b1;
        test_reset_latency();
        test_no_flags();
        test_chains();
        test_valid_gating();
        test_random();
        test_back_pressure();
        finish_run();
    end

endmodule

// ==== src/dep_check_top.sv ====
`include "dep_check_config.svh"

module dep_check_top
    import dep_check_pkg::*;
(
    input  logic       w_fire2_2,
    input  logic       rstn,
    input  logic       i_drive,
    output logic       o_free,
    input  uop_t       i_uops [`DC_LANES],
    output logic       o_drive,
    output dep_entry_t o_entries [`DC_WINDOW],
    input  logic       i_free
);

    // Gather to matrix
    logic     w_win_valid;
    uop_t     w_win_uops [`DC_WINDOW];
    logic     w_mat_ready;

    // Matrix to encoder
    logic     w_mat_valid;
    uop_t     w_mat_uops [`DC_WINDOW];
    dep_vec_t w_mat_dep_l [`DC_WINDOW];
    dep_vec_t w_mat_dep_r [`DC_WINDOW];
    logic     w_enc_ready;

    uop_gather u_gather (
        .w_fire2_2   (w_fire2_2),
        .rstn        (rstn),
        .i_drive     (i_drive),
        .o_free      (o_free),
        .i_uops      (i_uops),
        .o_win_valid (w_win_valid),
        .o_win_uops  (w_win_uops),
        .i_ready     (w_mat_ready)
    );

    raw_dep_matrix u_matrix (
        .w_fire2_2 (w_fire2_2),
        .rstn      (rstn),
        .i_valid   (w_win_valid),
        .o_ready   (w_mat_ready),
        .i_uops    (w_win_uops),
        .o_valid   (w_mat_valid),
        .o_uops    (w_mat_uops),
        .o_dep_l   (w_mat_dep_l),
        .o_dep_r   (w_mat_dep_r),
        .i_ready   (w_enc_ready)
    );

    dep_encoder u_encoder (
        .w_fire2_2 (w_fire2_2),
        .rstn      (rstn),
        .i_valid   (w_mat_valid),
        .o_ready   (w_enc_ready),
        .i_uops    (w_mat_uops),
        .i_dep_l   (w_mat_dep_l),
        .i_dep_r   (w_mat_dep_r),
        .o_drive   (o_drive),
        .o_entries (o_entries),
        .i_free    (i_free)
    );

endmodule

// ==== src/dep_encoder.sv ====
`include "dep_check_config.svh"

module dep_encoder
    import dep_check_pkg::*;
(
    input  logic       w_fire2_2,
    input  logic       rstn,
    input  logic       i_valid,
    output logic       o_ready,
    input  uop_t       i_uops [`DC_WINDOW],
    input  dep_vec_t   i_dep_l [`DC_WINDOW],
    input  dep_vec_t   i_dep_r [`DC_WINDOW],
    output logic       o_drive,
    output dep_entry_t o_entries [`DC_WINDOW],
    input  logic       i_free
);

    dep_entry_t [`DC_WINDOW-1:0] r_entries;
    dep_entry_t [`DC_WINDOW-1:0] w_packed;
    logic                        r_drive;
    logic                        w_load;

    // Highest set bit is the nearest older writer
    function automatic slot_idx_t nearest_producer(input dep_vec_t vec);
        slot_idx_t idx;
        idx = `DC_NO_DEP;
        for (int k = 0; k < `DC_WINDOW; k++) begin
            if (vec[k]) begin
                idx = slot_idx_t'(k);
            end
        end
        return idx;
    endfunction

    assign o_drive = r_drive;
    assign o_ready = !r_drive || i_free;
    assign w_load  = i_valid && o_ready;

    for (genvar s = 0; s < `DC_WINDOW; s++) begin : g_pack
        assign w_packed[s]  = {i_uops[s], nearest_producer(i_dep_l[s]),
                               nearest_producer(i_dep_r[s])};
        assign o_entries[s] = r_entries[s];
    end

    always_ff @(posedge w_fire2_2 or negedge rstn) begin
        if (!rstn) begin
            r_drive <= 1'b0;
        end else if (o_ready) begin
            r_drive <= i_valid;
        end
    end

    // Entries start at zero and stay put until the branch stage frees
    always_ff @(posedge w_fire2_2 or negedge rstn) begin
        if (!rstn) begin
            r_entries <= '0;
        end else if (w_load) begin
            r_entries <= w_packed;
        end
    end

    a_hold_entries: assert property (
        @(posedge w_fire2_2) disable iff (!rstn)
        (o_drive && !i_free) |=> (o_drive && $stable(r_entries))
    ) else $error("dep_encoder: entries changed while branch stage stalled");

endmodule

// ==== src/raw_dep_matrix.sv ====
`include "dep_check_config.svh"

module raw_dep_matrix
    import dep_check_pkg::*;
(
    input  logic     w_fire2_2,
    input  logic     rstn,
    input  logic     i_valid,
    output logic     o_ready,
    input  uop_t     i_uops [`DC_WINDOW],
    output logic     o_valid,
    output uop_t     o_uops [`DC_WINDOW],
    output dep_vec_t o_dep_l [`DC_WINDOW],
    output dep_vec_t o_dep_r [`DC_WINDOW],
    input  logic     i_ready
);

    reg_num_t w_dest [`DC_WINDOW];
    reg_num_t w_srcl [`DC_WINDOW];
    reg_num_t w_srcr [`DC_WINDOW];
    logic     w_dest_vld [`DC_WINDOW];
    logic     w_srcl_vld [`DC_WINDOW];
    logic     w_srcr_vld [`DC_WINDOW];
    dep_vec_t w_dep_l [`DC_WINDOW];
    dep_vec_t w_dep_r [`DC_WINDOW];
    logic     r_valid;
    logic     w_load;

    assign o_valid = r_valid;
    assign o_ready = !r_valid || i_ready;
    assign w_load  = i_valid && o_ready;

    for (genvar s = 0; s < `DC_WINDOW; s++) begin : g_field
        assign w_dest[s]     = i_uops[s][`DC_DEST_LSB +: `DC_REG_W];
        assign w_srcr[s]     = i_uops[s][`DC_SRCR_LSB +: `DC_REG_W];
        assign w_srcl[s]     = i_uops[s][`DC_SRCL_LSB +: `DC_REG_W];
        assign w_dest_vld[s] = i_uops[s][`DC_DEST_VLD];
        assign w_srcr_vld[s] = i_uops[s][`DC_SRCR_VLD];
        assign w_srcl_vld[s] = i_uops[s][`DC_SRCL_VLD];
    end

    // Consumer j against every older slot k
    always_comb begin
        for (int j = 0; j < `DC_WINDOW; j++) begin
            w_dep_l[j] = '0;
            w_dep_r[j] = '0;
            for (int k = 0; k < j; k++) begin
                w_dep_l[j][k] = w_srcl_vld[j] && w_dest_vld[k] && (w_srcl[j] == w_dest[k]);
                w_dep_r[j][k] = w_srcr_vld[j] && w_dest_vld[k] && (w_srcr[j] == w_dest[k]);
            end
        end
    end

    always_ff @(posedge w_fire2_2 or negedge rstn) begin
        if (!rstn) begin
            r_valid <= 1'b0;
        end else if (o_ready) begin
            r_valid <= i_valid;
        end
    end

    always_ff @(posedge w_fire2_2) begin
        if (w_load) begin
            o_uops  <= i_uops;
            o_dep_l <= w_dep_l;
            o_dep_r <= w_dep_r;
        end
    end

    // Only older slots may appear as producers
    for (genvar j = 0; j < `DC_WINDOW; j++) begin : g_chk
        a_older_only: assert property (
            @(posedge w_fire2_2) disable iff (!rstn)
            o_valid |-> ((o_dep_l[j] >> j) == '0) && ((o_dep_r[j] >> j) == '0)
        ) else $error("raw_dep_matrix: slot %0d depends on itself or younger", j);
    end

endmodule

// ==== src/uop_gather.sv ====
`include "dep_check_config.svh"

module uop_gather
    import dep_check_pkg::*;
(
    input  logic w_fire2_2,
    input  logic rstn,
    input  logic i_drive,
    output logic o_free,
    input  uop_t i_uops [`DC_LANES],
    output logic o_win_valid,
    output uop_t o_win_uops [`DC_WINDOW],
    input  logic i_ready
);

    gather_state_t r_state;
    logic          w_accept;

    // No beat is taken while a full window waits
    assign o_free      = (r_state != WINDOW_FULL);
    assign o_win_valid = (r_state == WINDOW_FULL);
    assign w_accept    = i_drive && o_free;

    always_ff @(posedge w_fire2_2 or negedge rstn) begin
        if (!rstn) begin
            r_state <= GATHER_LOW;
        end else begin
            case (r_state)
                GATHER_LOW: begin
                    if (w_accept) begin
                        r_state <= GATHER_HIGH;
                    end
                end
                GATHER_HIGH: begin
                    if (w_accept) begin
                        r_state <= WINDOW_FULL;
                    end
                end
                WINDOW_FULL: begin
                    if (i_ready) begin
                        r_state <= GATHER_LOW;
                    end
                end
                default: begin
                    r_state <= GATHER_LOW;
                end
            endcase
        end
    end

    // First beat fills slots 0-7, second beat slots 8-15
    always_ff @(posedge w_fire2_2) begin
        if (w_accept) begin
            for (int i = 0; i < `DC_LANES; i++) begin
                if (r_state == GATHER_LOW) begin
                    o_win_uops[i] <= i_uops[i];
                end else begin
                    o_win_uops[i + `DC_LANES] <= i_uops[i];
                end
            end
        end
    end

    // Decoder must hold off while the window is full
    a_no_drive_when_full: assert property (
        @(posedge w_fire2_2) disable iff (!rstn)
        !(i_drive && !o_free)
    ) else $error("uop_gather: beat driven while o_free is low");

endmodule

// ==== src/dep_check_pkg.sv ====
`include "dep_check_config.svh"

package dep_check_pkg;

    typedef logic [`DC_UOP_W-1:0]   uop_t;
    typedef logic [`DC_REG_W-1:0]   reg_num_t;
    typedef logic [`DC_SLOT_W-1:0]  slot_idx_t;

    // Bit k set when slot k produces the operand
    typedef logic [`DC_WINDOW-1:0]  dep_vec_t;

    // {uop, left index, right index}
    typedef logic [`DC_ENTRY_W-1:0] dep_entry_t;

    // Window assembly from two beats
    typedef enum logic [1:0] {
        GATHER_LOW  = 2'd0,
        GATHER_HIGH = 2'd1,
        WINDOW_FULL = 2'd2
    } gather_state_t;

endpackage

// ==== include/dep_check_config.svh ====
`ifndef DEP_CHECK_CONFIG_SVH
`define DEP_CHECK_CONFIG_SVH

// Micro-op and window geometry
`define DC_UOP_W    105
`define DC_REG_W    5
`define DC_LANES    8
`define DC_WINDOW   16
`define DC_SLOT_W   4
`define DC_ENTRY_W  113

// Register fields inside a micro-op
`define DC_DEST_LSB 0
`define DC_SRCR_LSB 5
`define DC_SRCL_LSB 10
`define DC_DEST_VLD 15
`define DC_SRCR_VLD 16
`define DC_SRCL_VLD 17

// Slot 15 never produces, so this code is free
`define DC_NO_DEP   4'hF

`endif
